//--- rtl/burst_split_config.svh
`ifndef BURST_SPLIT_CONFIG_SVH
`define BURST_SPLIT_CONFIG_SVH

// ----------------------------------------
// Bus widths
// ----------------------------------------
`define BS_ADDR_W 32
`define BS_DATA_W 32
`define BS_ID_W 4

// AXI4 burst length field
`define BS_LEN_W 8

// ----------------------------------------
// Outstanding bursts
// ----------------------------------------
// Entries in each in-order length queue
`define BS_MAX_TXNS 4

`endif

//--- rtl/burst_split_pkg.sv
`include "burst_split_config.svh"

package burst_split_pkg;

  // One strobe bit per data byte
  localparam int unsigned STRB_W = `BS_DATA_W / 8;

  typedef logic [`BS_ADDR_W-1:0] addr_t;
  typedef logic [`BS_DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0]     strb_t;
  typedef logic [`BS_ID_W-1:0]   id_t;
  typedef logic [`BS_LEN_W-1:0]  len_t;
  typedef logic [2:0]            size_t;

  // WRAP is not handled by the splitter
  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01
  } burst_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_e;

  // ----------------------------------------
  // Channel payloads
  // ----------------------------------------
  // Address request, shared by AW and AR
  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_e burst;
  } ax_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_chan_t;

  typedef struct packed {
    id_t   id;
    resp_e resp;
  } b_chan_t;

  typedef struct packed {
    id_t   id;
    data_t data;
    resp_e resp;
    logic  last;
  } r_chan_t;

endpackage

//--- rtl/ax_splitter.sv
module ax_splitter #(
  parameter type chan_t = burst_split_pkg::ax_chan_t
) (
  input  logic  clk_i,
  input  logic  arst_n_i,

  // Upstream request
  input  chan_t ax_i,
  input  logic  ax_valid_i,
  output logic  ax_ready_o,

  // Downstream single-beat requests
  output chan_t ax_o,
  output logic  ax_valid_o,
  input  logic  ax_ready_i,

  // Length queue
  input  logic  q_full_i,
  output logic  q_push_o
);

  import burst_split_pkg::*;

  typedef enum logic {
    IDLE,
    BUSY
  } state_e;

  state_e state_d, state_q;
  chan_t  ax_d, ax_q;

  // Step a request to its next beat
  function automatic chan_t next_beat(chan_t ax);
    chan_t nxt;
    nxt     = ax;
    nxt.len = ax.len - 1'b1;
    if (ax.burst == BURST_INCR) begin
      // Align to the beat size, then one beat further
      nxt.addr = (ax.addr >> ax.size) << ax.size;
      nxt.addr = nxt.addr + (addr_t'(1) << ax.size);
    end
    return nxt;
  endfunction

  // ----------------------------------------
  // Request FSM
  // ----------------------------------------
  always_comb begin
    state_d    = state_q;
    ax_d       = ax_q;
    ax_valid_o = 1'b0;
    ax_ready_o = 1'b0;
    q_push_o   = 1'b0;

    // Every downstream request is a single beat
    ax_o       = (state_q == BUSY) ? ax_q : ax_i;
    ax_o.len   = '0;

    unique case (state_q)
      IDLE: begin
        if (ax_valid_i && !q_full_i) begin
          ax_valid_o = 1'b1;
          if (ax_i.len == '0) begin
            // Nothing to split, straight through
            ax_ready_o = ax_ready_i;
            q_push_o   = ax_ready_i;
          end else begin
            // Take the burst now, first beat goes out in the same cycle
            ax_ready_o = 1'b1;
            q_push_o   = 1'b1;
            state_d    = BUSY;
            ax_d       = ax_ready_i ? next_beat(ax_i) : ax_i;
          end
        end
      end
      BUSY: begin
        ax_valid_o = 1'b1;
        if (ax_ready_i) begin
          if (ax_q.len == '0) begin
            state_d = IDLE;
          end else begin
            ax_d = next_beat(ax_q);
          end
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Held copy of the burst being split
  always_ff @(posedge clk_i) begin
    ax_q <= ax_d;
  end

endmodule

//--- rtl/burst_len_queue.sv
`include "burst_split_config.svh"

module burst_len_queue #(
  parameter int unsigned DEPTH = `BS_MAX_TXNS
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,

  // Write side, one entry per accepted burst
  input  logic                  push_i,
  input  burst_split_pkg::len_t len_i,
  output logic                  full_o,

  // Head entry, counted down per response beat
  input  logic                  dec_i,
  output burst_split_pkg::len_t remain_o,
  output logic                  nonempty_o
);

  import burst_split_pkg::*;

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [CNT_W-1:0] cnt_t;

  len_t mem_q [DEPTH];
  ptr_t wr_ptr_q, rd_ptr_q;
  cnt_t count_q;
  logic push;
  logic dec;
  logic pop;

  // Wrap at DEPTH, which need not be a power of two
  function automatic ptr_t ptr_inc(ptr_t ptr);
    ptr_t nxt;
    if (ptr == ptr_t'(DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  assign full_o     = (count_q == cnt_t'(DEPTH));
  assign nonempty_o = (count_q != '0);
  assign remain_o   = mem_q[rd_ptr_q];

  assign push = push_i && !full_o;
  assign dec  = dec_i && nonempty_o;
  // Last beat of the head burst retires the entry
  assign pop  = dec && (remain_o == '0);

  // ----------------------------------------
  // Pointers and fill count
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // ----------------------------------------
  // Entry storage
  // ----------------------------------------
  // Push lands on the head only when empty, so it never meets a decrement
  always_ff @(posedge clk_i) begin
    if (dec && !pop) begin
      mem_q[rd_ptr_q] <= remain_o - 1'b1;
    end
    if (push) begin
      mem_q[wr_ptr_q] <= len_i;
    end
  end

endmodule

//--- rtl/resp_ctrl.sv
module resp_ctrl (
  input  logic                     clk_i,
  input  logic                     arst_n_i,

  // B channel
  input  burst_split_pkg::b_chan_t mst_b_i,
  input  logic                     mst_b_valid_i,
  output logic                     mst_b_ready_o,
  output burst_split_pkg::b_chan_t slv_b_o,
  output logic                     slv_b_valid_o,
  input  logic                     slv_b_ready_i,
  input  burst_split_pkg::len_t    w_remain_i,
  input  logic                     w_nonempty_i,
  output logic                     w_dec_o,

  // R channel
  input  burst_split_pkg::r_chan_t mst_r_i,
  input  logic                     mst_r_valid_i,
  output logic                     mst_r_ready_o,
  output burst_split_pkg::r_chan_t slv_r_o,
  output logic                     slv_r_valid_o,
  input  logic                     slv_r_ready_i,
  input  burst_split_pkg::len_t    r_remain_i,
  input  logic                     r_nonempty_i,
  output logic                     r_dec_o,

  // W channel
  input  burst_split_pkg::w_chan_t slv_w_i,
  input  logic                     slv_w_valid_i,
  output logic                     slv_w_ready_o,
  output burst_split_pkg::w_chan_t mst_w_o,
  output logic                     mst_w_valid_o,
  input  logic                     mst_w_ready_i
);

  import burst_split_pkg::*;

  typedef enum logic {B_READY, B_WAIT} b_state_e;
  typedef enum logic {R_FEED, R_WAIT} r_state_e;

  b_state_e b_state_d, b_state_q;
  r_state_e r_state_d, r_state_q;
  logic     b_err_d, b_err_q;
  logic     r_last_d, r_last_q;
  logic     beat_err;

  assign beat_err = (mst_b_i.resp == RESP_SLVERR);

  // ----------------------------------------
  // W channel
  // ----------------------------------------
  always_comb begin
    mst_w_o      = slv_w_i;
    mst_w_o.last = 1'b1;
  end
  assign mst_w_valid_o = slv_w_valid_i;
  assign slv_w_ready_o = mst_w_ready_i;

  // ----------------------------------------
  // B channel
  // ----------------------------------------
  always_comb begin
    b_state_d     = b_state_q;
    b_err_d       = b_err_q;
    mst_b_ready_o = 1'b0;
    slv_b_valid_o = 1'b0;
    w_dec_o       = 1'b0;
    slv_b_o       = mst_b_i;
    // Merged response of the whole burst
    slv_b_o.resp  = (b_err_q || beat_err) ? RESP_SLVERR : RESP_OKAY;

    unique case (b_state_q)
      B_READY: begin
        if (mst_b_valid_i && w_nonempty_i) begin
          w_dec_o = 1'b1;
          if (w_remain_i == '0) begin
            slv_b_valid_o = 1'b1;
            if (slv_b_ready_i) begin
              mst_b_ready_o = 1'b1;
              b_err_d       = 1'b0;
            end else begin
              b_state_d = B_WAIT;
              b_err_d   = b_err_q || beat_err;
            end
          end else begin
            // Intermediate beat, absorbed here
            mst_b_ready_o = 1'b1;
            b_err_d       = b_err_q || beat_err;
          end
        end
      end
      B_WAIT: begin
        // Downstream B held until upstream takes it
        slv_b_valid_o = 1'b1;
        if (mst_b_valid_i && slv_b_ready_i) begin
          mst_b_ready_o = 1'b1;
          b_err_d       = 1'b0;
          b_state_d     = B_READY;
        end
      end
      default: b_state_d = B_READY;
    endcase
  end

  // ----------------------------------------
  // R channel
  // ----------------------------------------
  always_comb begin
    r_state_d     = r_state_q;
    r_last_d      = r_last_q;
    mst_r_ready_o = 1'b0;
    slv_r_valid_o = 1'b0;
    r_dec_o       = 1'b0;
    slv_r_o       = mst_r_i;
    slv_r_o.last  = r_last_q;

    unique case (r_state_q)
      R_FEED: begin
        if (mst_r_valid_i && r_nonempty_i) begin
          r_dec_o       = 1'b1;
          r_last_d      = (r_remain_i == '0);
          slv_r_o.last  = r_last_d;
          slv_r_valid_o = 1'b1;
          if (slv_r_ready_i) begin
            mst_r_ready_o = 1'b1;
          end else begin
            r_state_d = R_WAIT;
          end
        end
      end
      R_WAIT: begin
        slv_r_valid_o = mst_r_valid_i;
        if (mst_r_valid_i && slv_r_ready_i) begin
          mst_r_ready_o = 1'b1;
          r_state_d     = R_FEED;
        end
      end
      default: r_state_d = R_FEED;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      b_state_q <= B_READY;
      b_err_q   <= 1'b0;
      r_state_q <= R_FEED;
      r_last_q  <= 1'b0;
    end else begin
      b_state_q <= b_state_d;
      b_err_q   <= b_err_d;
      r_state_q <= r_state_d;
      r_last_q  <= r_last_d;
    end
  end

endmodule

//--- rtl/axi_burst_splitter.sv
`include "burst_split_config.svh"

module axi_burst_splitter (
  input  logic                      clk_i,
  input  logic                      arst_n_i,

  // Upstream port
  input  burst_split_pkg::ax_chan_t slv_aw_i,
  input  logic                      slv_aw_valid_i,
  output logic                      slv_aw_ready_o,
  input  burst_split_pkg::w_chan_t  slv_w_i,
  input  logic                      slv_w_valid_i,
  output logic                      slv_w_ready_o,
  output burst_split_pkg::b_chan_t  slv_b_o,
  output logic                      slv_b_valid_o,
  input  logic                      slv_b_ready_i,
  input  burst_split_pkg::ax_chan_t slv_ar_i,
  input  logic                      slv_ar_valid_i,
  output logic                      slv_ar_ready_o,
  output burst_split_pkg::r_chan_t  slv_r_o,
  output logic                      slv_r_valid_o,
  input  logic                      slv_r_ready_i,

  // Downstream port, single beats only
  output burst_split_pkg::ax_chan_t mst_aw_o,
  output logic                      mst_aw_valid_o,
  input  logic                      mst_aw_ready_i,
  output burst_split_pkg::w_chan_t  mst_w_o,
  output logic                      mst_w_valid_o,
  input  logic                      mst_w_ready_i,
  input  burst_split_pkg::b_chan_t  mst_b_i,
  input  logic                      mst_b_valid_i,
  output logic                      mst_b_ready_o,
  output burst_split_pkg::ax_chan_t mst_ar_o,
  output logic                      mst_ar_valid_o,
  input  logic                      mst_ar_ready_i,
  input  burst_split_pkg::r_chan_t  mst_r_i,
  input  logic                      mst_r_valid_i,
  output logic                      mst_r_ready_o
);

  import burst_split_pkg::*;

  logic w_q_full, w_q_push, w_nonempty, w_dec;
  logic r_q_full, r_q_push, r_nonempty, r_dec;
  len_t w_remain, r_remain;

  // ----------------------------------------
  // Write path
  // ----------------------------------------
  ax_splitter #(
    .chan_t(ax_chan_t)
  ) aw_split (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .ax_i      (slv_aw_i),
    .ax_valid_i(slv_aw_valid_i),
    .ax_ready_o(slv_aw_ready_o),
    .ax_o      (mst_aw_o),
    .ax_valid_o(mst_aw_valid_o),
    .ax_ready_i(mst_aw_ready_i),
    .q_full_i  (w_q_full),
    .q_push_o  (w_q_push)
  );

  burst_len_queue #(
    .DEPTH(`BS_MAX_TXNS)
  ) w_len_q (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .push_i    (w_q_push),
    .len_i     (slv_aw_i.len),
    .full_o    (w_q_full),
    .dec_i     (w_dec),
    .remain_o  (w_remain),
    .nonempty_o(w_nonempty)
  );

  // ----------------------------------------
  // Read path
  // ----------------------------------------
  ax_splitter #(
    .chan_t(ax_chan_t)
  ) ar_split (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .ax_i      (slv_ar_i),
    .ax_valid_i(slv_ar_valid_i),
    .ax_ready_o(slv_ar_ready_o),
    .ax_o      (mst_ar_o),
    .ax_valid_o(mst_ar_valid_o),
    .ax_ready_i(mst_ar_ready_i),
    .q_full_i  (r_q_full),
    .q_push_o  (r_q_push)
  );

  burst_len_queue #(
    .DEPTH(`BS_MAX_TXNS)
  ) r_len_q (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .push_i    (r_q_push),
    .len_i     (slv_ar_i.len),
    .full_o    (r_q_full),
    .dec_i     (r_dec),
    .remain_o  (r_remain),
    .nonempty_o(r_nonempty)
  );

  // Response filtering and W feedthrough
  resp_ctrl ctrl (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .mst_b_i      (mst_b_i),
    .mst_b_valid_i(mst_b_valid_i),
    .mst_b_ready_o(mst_b_ready_o),
    .slv_b_o      (slv_b_o),
    .slv_b_valid_o(slv_b_valid_o),
    .slv_b_ready_i(slv_b_ready_i),
    .w_remain_i   (w_remain),
    .w_nonempty_i (w_nonempty),
    .w_dec_o      (w_dec),
    .mst_r_i      (mst_r_i),
    .mst_r_valid_i(mst_r_valid_i),
    .mst_r_ready_o(mst_r_ready_o),
    .slv_r_o      (slv_r_o),
    .slv_r_valid_o(slv_r_valid_o),
    .slv_r_ready_i(slv_r_ready_i),
    .r_remain_i   (r_remain),
    .r_nonempty_i (r_nonempty),
    .r_dec_o      (r_dec),
    .slv_w_i      (slv_w_i),
    .slv_w_valid_i(slv_w_valid_i),
    .slv_w_ready_o(slv_w_ready_o),
    .mst_w_o      (mst_w_o),
    .mst_w_valid_o(mst_w_valid_o),
    .mst_w_ready_i(mst_w_ready_i)
  );

endmodule

//--- testbench/burst_split_asserts.sv
module burst_split_asserts (
  input logic                      clk_i,
  input logic                      arst_n_i,
  input burst_split_pkg::ax_chan_t mst_aw_o,
  input logic                      mst_aw_valid_o,
  input burst_split_pkg::ax_chan_t mst_ar_o,
  input logic                      mst_ar_valid_o,
  input burst_split_pkg::w_chan_t  mst_w_o,
  input logic                      mst_w_valid_o,
  input burst_split_pkg::b_chan_t  slv_b_o,
  input logic                      slv_b_valid_o,
  input logic                      slv_b_ready_i
);

  import burst_split_pkg::*;

  // ----------------------------------------
  // Downstream single beats
  // ----------------------------------------
  aw_single: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mst_aw_valid_o |-> (mst_aw_o.len == '0))
    else $error("Downstream AW request with nonzero len");

  ar_single: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mst_ar_valid_o |-> (mst_ar_o.len == '0))
    else $error("Downstream AR request with nonzero len");

  w_last: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mst_w_valid_o |-> mst_w_o.last)
    else $error("Downstream W beat without last");

  // Upstream B held under back-pressure
  b_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (slv_b_valid_o && !slv_b_ready_i) |=> $stable(slv_b_o))
    else $error("Upstream B changed while waiting for ready");

endmodule

bind axi_burst_splitter burst_split_asserts asserts (
  .clk_i         (clk_i),
  .arst_n_i      (arst_n_i),
  .mst_aw_o      (mst_aw_o),
  .mst_aw_valid_o(mst_aw_valid_o),
  .mst_ar_o      (mst_ar_o),
  .mst_ar_valid_o(mst_ar_valid_o),
  .mst_w_o       (mst_w_o),
  .mst_w_valid_o (mst_w_valid_o),
  .slv_b_o       (slv_b_o),
  .slv_b_valid_o (slv_b_valid_o),
  .slv_b_ready_i (slv_b_ready_i)
);

//--- testbench/tb_axi_burst_splitter.sv
module tb_axi_burst_splitter;

  import burst_split_pkg::*;

  localparam int NUM_BURSTS = 42;

  logic     clk, arst_n;
  ax_chan_t slv_aw, slv_ar, mst_aw, mst_ar;
  w_chan_t  slv_w, mst_w;
  b_chan_t  slv_b, mst_b;
  r_chan_t  slv_r, mst_r;
  logic     slv_aw_valid, slv_aw_ready, slv_w_valid, slv_w_ready;
  logic     slv_b_valid, slv_b_ready, slv_ar_valid, slv_ar_ready;
  logic     slv_r_valid, slv_r_ready, mst_aw_valid, mst_aw_ready;
  logic     mst_w_valid, mst_w_ready, mst_b_valid, mst_b_ready;
  logic     mst_ar_valid, mst_ar_ready, mst_r_valid, mst_r_ready;

  // Expected traffic and downstream bookkeeping
  ax_chan_t exp_aw_q[$], exp_ar_q[$], dn_aw_q[$], dn_ar_q[$];
  w_chan_t  exp_w_q[$];
  b_chan_t  exp_b_q[$];
  r_chan_t  exp_r_q[$];
  ax_chan_t dn_b_ax, dn_r_ax;
  int       dn_w_cnt, errors, checks, tests_run, tests_failed, errors_at_start;

  axi_burst_splitter dut (
    .clk_i(clk), .arst_n_i(arst_n),
    .slv_aw_i(slv_aw), .slv_aw_valid_i(slv_aw_valid), .slv_aw_ready_o(slv_aw_ready),
    .slv_w_i(slv_w), .slv_w_valid_i(slv_w_valid), .slv_w_ready_o(slv_w_ready),
    .slv_b_o(slv_b), .slv_b_valid_o(slv_b_valid), .slv_b_ready_i(slv_b_ready),
    .slv_ar_i(slv_ar), .slv_ar_valid_i(slv_ar_valid), .slv_ar_ready_o(slv_ar_ready),
    .slv_r_o(slv_r), .slv_r_valid_o(slv_r_valid), .slv_r_ready_i(slv_r_ready),
    .mst_aw_o(mst_aw), .mst_aw_valid_o(mst_aw_valid), .mst_aw_ready_i(mst_aw_ready),
    .mst_w_o(mst_w), .mst_w_valid_o(mst_w_valid), .mst_w_ready_i(mst_w_ready),
    .mst_b_i(mst_b), .mst_b_valid_i(mst_b_valid), .mst_b_ready_o(mst_b_ready),
    .mst_ar_o(mst_ar), .mst_ar_valid_o(mst_ar_valid), .mst_ar_ready_i(mst_ar_ready),
    .mst_r_i(mst_r), .mst_r_valid_i(mst_r_valid), .mst_r_ready_o(mst_r_ready)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  function automatic logic in_err_range(addr_t addr);
    return (addr[11:8] == 4'hF);
  endfunction

  function automatic data_t mem_data(addr_t addr);
    return data_t'({addr[15:0], addr[31:16]} ^ 32'h5A3C_96E1);
  endfunction

  // First beat at the start address, later beats aligned for INCR
  function automatic addr_t beat_addr(ax_chan_t ax, int k);
    addr_t base;
    if (ax.burst == BURST_FIXED || k == 0) begin
      return ax.addr;
    end
    base = (ax.addr >> ax.size) << ax.size;
    return base + (addr_t'(k) << ax.size);
  endfunction

  function automatic resp_e burst_resp(ax_chan_t ax);
    resp_e resp;
    resp = RESP_OKAY;
    for (int k = 0; k <= int'(ax.len); k++) begin
      if (in_err_range(beat_addr(ax, k))) begin
        resp = RESP_SLVERR;
      end
    end
    return resp;
  endfunction

  function automatic ax_chan_t make_ax(burst_e burst, int unsigned max_len);
    ax_chan_t ax;
    ax.id    = id_t'($urandom);
    ax.addr  = addr_t'($urandom);
    ax.len   = len_t'($urandom_range(max_len));
    ax.size  = size_t'($urandom_range(2));
    ax.burst = burst;
    return ax;
  endfunction

  // ----------------------------------------
  // Upstream drivers, entered 1 unit after a rising edge
  // ----------------------------------------
  task automatic drive_aw(ax_chan_t ax);
    slv_aw       = ax;
    slv_aw_valid = 1'b1;
    @(negedge clk);
    while (!slv_aw_ready) @(negedge clk);
    @(posedge clk);
    #1 slv_aw_valid = 1'b0;
  endtask

  task automatic drive_ar(ax_chan_t ax);
    slv_ar       = ax;
    slv_ar_valid = 1'b1;
    @(negedge clk);
    while (!slv_ar_ready) @(negedge clk);
    @(posedge clk);
    #1 slv_ar_valid = 1'b0;
  endtask

  task automatic drive_w(w_chan_t w);
    slv_w       = w;
    slv_w_valid = 1'b1;
    @(negedge clk);
    while (!slv_w_ready) @(negedge clk);
    @(posedge clk);
    #1 slv_w_valid = 1'b0;
  endtask

  task automatic issue_write(ax_chan_t ax);
    w_chan_t  beats[$];
    w_chan_t  w;
    ax_chan_t e;
    b_chan_t  b;
    for (int k = 0; k <= int'(ax.len); k++) begin
      w.data = data_t'($urandom);
      w.strb = strb_t'($urandom);
      w.last = (k == int'(ax.len));
      beats.push_back(w);
      w.last = 1'b1;
      exp_w_q.push_back(w);
      e      = ax;
      e.addr = beat_addr(ax, k);
      e.len  = '0;
      exp_aw_q.push_back(e);
    end
    b.id   = ax.id;
    b.resp = burst_resp(ax);
    exp_b_q.push_back(b);
    fork
      drive_aw(ax);
      begin
        for (int k = 0; k < beats.size(); k++) drive_w(beats[k]);
      end
    join
  endtask

  task automatic issue_read(ax_chan_t ax);
    ax_chan_t e;
    r_chan_t  r;
    for (int k = 0; k <= int'(ax.len); k++) begin
      e      = ax;
      e.addr = beat_addr(ax, k);
      e.len  = '0;
      exp_ar_q.push_back(e);
      r.id   = ax.id;
      r.data = mem_data(e.addr);
      r.resp = in_err_range(e.addr) ? RESP_SLVERR : RESP_OKAY;
      r.last = (k == int'(ax.len));
      exp_r_q.push_back(r);
    end
    drive_ar(ax);
  endtask

  // ----------------------------------------
  // Downstream subordinate model
  // ----------------------------------------
  always @(posedge clk) begin
    #1;
    mst_aw_ready = 1'($urandom_range(1));
    mst_w_ready  = 1'($urandom_range(1));
    mst_ar_ready = 1'($urandom_range(1));
    slv_b_ready  = ($urandom_range(3) != 0);
    slv_r_ready  = ($urandom_range(3) != 0);
  end

  always begin
    @(posedge clk);
    #1;
    if (dn_aw_q.size() > 0 && dn_w_cnt > 0) begin
      dn_b_ax = dn_aw_q.pop_front();
      dn_w_cnt--;
      repeat ($urandom_range(3)) begin
        @(posedge clk);
        #1;
      end
      mst_b.id    = dn_b_ax.id;
      mst_b.resp  = in_err_range(dn_b_ax.addr) ? RESP_SLVERR : RESP_OKAY;
      mst_b_valid = 1'b1;
      @(negedge clk);
      while (!mst_b_ready) @(negedge clk);
      @(posedge clk);
      #1 mst_b_valid = 1'b0;
    end
  end

  always begin
    @(posedge clk);
    #1;
    if (dn_ar_q.size() > 0) begin
      dn_r_ax = dn_ar_q.pop_front();
      repeat ($urandom_range(3)) begin
        @(posedge clk);
        #1;
      end
      mst_r.id    = dn_r_ax.id;
      mst_r.data  = mem_data(dn_r_ax.addr);
      mst_r.resp  = in_err_range(dn_r_ax.addr) ? RESP_SLVERR : RESP_OKAY;
      mst_r.last  = 1'b1;
      mst_r_valid = 1'b1;
      @(negedge clk);
      while (!mst_r_ready) @(negedge clk);
      @(posedge clk);
      #1 mst_r_valid = 1'b0;
    end
  end

  // ----------------------------------------
  // Comparator, sampled mid-cycle
  // ----------------------------------------
  task automatic report_mismatch(string what, logic [63:0] got, logic [63:0] exp);
    errors++;
    $display("** Error [%0t] %s mismatch: got %h, expected %h", $time, what, got, exp);
  endtask

  task automatic report_extra(string what);
    errors++;
    $display("Unexpected %s with nothing outstanding at time %0t", what, $time);
  endtask

  always @(negedge clk) begin
    if (arst_n) begin
      if (mst_aw_valid && mst_aw_ready) begin
        dn_aw_q.push_back(mst_aw);
        checks++;
        assert (exp_aw_q.size() > 0) else report_extra("downstream AW request");
        if (exp_aw_q.size() > 0) begin
          assert (mst_aw == exp_aw_q[0])
            else report_mismatch("AW", 64'(mst_aw), 64'(exp_aw_q[0]));
          void'(exp_aw_q.pop_front());
        end
      end
      if (mst_w_valid && mst_w_ready) begin
        dn_w_cnt++;
        checks++;
        assert (exp_w_q.size() > 0) else report_extra("downstream W beat");
        if (exp_w_q.size() > 0) begin
          assert (mst_w == exp_w_q[0])
            else report_mismatch("W", 64'(mst_w), 64'(exp_w_q[0]));
          void'(exp_w_q.pop_front());
        end
      end
      if (mst_ar_valid && mst_ar_ready) begin
        dn_ar_q.push_back(mst_ar);
        checks++;
        assert (exp_ar_q.size() > 0) else report_extra("downstream AR request");
        if (exp_ar_q.size() > 0) begin
          assert (mst_ar == exp_ar_q[0])
            else report_mismatch("AR", 64'(mst_ar), 64'(exp_ar_q[0]));
          void'(exp_ar_q.pop_front());
        end
      end
      if (slv_b_valid && slv_b_ready) begin
        checks++;
        assert (exp_b_q.size() > 0) else report_extra("upstream B response");
        if (exp_b_q.size() > 0) begin
          assert (slv_b == exp_b_q[0])
            else report_mismatch("B", 64'(slv_b), 64'(exp_b_q[0]));
          void'(exp_b_q.pop_front());
        end
      end
      if (slv_r_valid && slv_r_ready) begin
        checks++;
        assert (exp_r_q.size() > 0) else report_extra("upstream R beat");
        if (exp_r_q.size() > 0) begin
          assert (slv_r == exp_r_q[0])
            else report_mismatch("R", 64'(slv_r), 64'(exp_r_q[0]));
          void'(exp_r_q.pop_front());
        end
      end
    end
  end

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  task automatic wait_idle();
    while (exp_aw_q.size() + exp_w_q.size() + exp_b_q.size() +
           exp_ar_q.size() + exp_r_q.size() != 0) @(negedge clk);
    @(posedge clk);
    #1;
  endtask

  task automatic end_test(string name);
    wait_idle();
    tests_run++;
    if (errors > errors_at_start) begin
      tests_failed++;
      $display("Test %0d %s: failed with %0d errors", tests_run, name,
               errors - errors_at_start);
    end else begin
      $display("Test %0d %s: passed", tests_run, name);
    end
    errors_at_start = errors;
  endtask

  initial begin
    ax_chan_t err_ax;
    void'($urandom(91));
    {slv_aw, slv_ar, slv_w, mst_b, mst_r} = '0;
    {slv_aw_valid, slv_w_valid, slv_ar_valid, mst_b_valid, mst_r_valid} = '0;
    {slv_b_ready, slv_r_ready, mst_aw_ready, mst_w_ready, mst_ar_ready} = '0;
    {errors, checks, tests_run, tests_failed, errors_at_start, dn_w_cnt} = '0;
    arst_n = 1'b0;
    repeat (10) @(posedge clk);
    #1 arst_n = 1'b1;
    @(posedge clk);
    #1;

    for (int i = 0; i < 6; i++) issue_write(make_ax(BURST_INCR, 7));
    end_test("INCR write bursts");

    for (int i = 0; i < 6; i++) issue_read(make_ax(BURST_FIXED, 7));
    end_test("FIXED read bursts");

    // Eight word beats that stay in the error window, enter it or leave it
    for (int i = 0; i < 6; i++) begin
      err_ax      = make_ax(BURST_INCR, 7);
      err_ax.size = 3'd2;
      err_ax.len  = len_t'(7);
      case (i % 3)
        0:       err_ax.addr[11:4] = 8'hF3;
        1:       err_ax.addr[11:4] = 8'hEF;
        default: err_ax.addr[11:4] = 8'hFF;
      endcase
      issue_write(err_ax);
    end
    end_test("merged write errors");

    for (int i = 0; i < 4; i++) begin
      issue_write(make_ax((i % 2 == 1) ? BURST_FIXED : BURST_INCR, 0));
      issue_read(make_ax((i % 2 == 1) ? BURST_INCR : BURST_FIXED, 0));
    end
    end_test("single-beat requests");

    fork
      for (int i = 0; i < 8; i++) begin
        issue_write(make_ax(($urandom_range(1) == 1) ? BURST_INCR : BURST_FIXED, 7));
      end
      for (int i = 0; i < 8; i++) begin
        issue_read(make_ax(($urandom_range(1) == 1) ? BURST_INCR : BURST_FIXED, 7));
      end
    join
    end_test("overlapping bursts with back-pressure");

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Watchdog sized from the burst count
  initial begin
    #(NUM_BURSTS * 64 * 20);
    $display("Timeout: the run did not finish within %0d time units", NUM_BURSTS * 64 * 20);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- axi_burst_splitter.f
+incdir+rtl
rtl/burst_split_pkg.sv
rtl/ax_splitter.sv
rtl/burst_len_queue.sv
rtl/resp_ctrl.sv
rtl/axi_burst_splitter.sv
testbench/burst_split_asserts.sv
testbench/tb_axi_burst_splitter.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f axi_burst_splitter.f --top-module tb_axi_burst_splitter -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
  exit 1
fi
grep -q "STATUS: PASS" sim.log
